// File: logic/rename_pkg.sv
package rename_pkg;

    localparam int NUM_AREGS = 32;
    localparam int NUM_PREGS = 64;
    localparam int AREG_W    = $clog2(NUM_AREGS);
    localparam int PREG_W    = $clog2(NUM_PREGS);

    localparam int ROB_DEPTH = 16;
    localparam int ROB_IDX_W = $clog2(ROB_DEPTH);

    localparam int IQ_DEPTH  = 8;

    // Physical registers not claimed by the reset identity map
    localparam int FL_DEPTH  = NUM_PREGS - NUM_AREGS;
    localparam int FL_IDX_W  = $clog2(FL_DEPTH);

    localparam int OP_W      = 2;
    localparam int INST_W    = OP_W + 3 * AREG_W;   // Packed as {op, rd, rs1, rs2}

    // Instruction class decides which register fields are live
    typedef enum logic [OP_W-1:0] {
        OP_REG   = 2'b00,   // rs1, rs2 -> rd
        OP_IMM   = 2'b01,   // rs1 -> rd
        OP_STORE = 2'b10,   // rs1, rs2, no rd
        OP_LUI   = 2'b11    // rd only
    } op_e;

endpackage

// File: logic/inst_queue.sv
module inst_queue #(
    parameter int WIDTH = 17,
    parameter int DEPTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] wdata_i,
    input  logic             wvalid_i,
    output logic             wready_o,
    output logic [WIDTH-1:0] rdata_o,
    output logic             rvalid_o,
    input  logic             rready_i
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign wready_o = count != CNT_W'(DEPTH);   // No bypass when full
    assign rvalid_o = count != '0;
    assign rdata_o  = mem[head];
    assign push     = wvalid_i && wready_o;
    assign pop      = rvalid_o && rready_i;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= (tail == PTR_W'(DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == PTR_W'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: logic/free_list.sv
module free_list
    import rename_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              push_i,
    input  logic [PREG_W-1:0] push_preg_i,
    input  logic              pop_i,
    output logic [PREG_W-1:0] head_preg_o,
    output logic              empty_o
);

    logic [PREG_W-1:0]   mem [FL_DEPTH];
    logic [FL_IDX_W-1:0] head;
    logic [FL_IDX_W-1:0] tail;
    logic [FL_IDX_W:0]   count;

    assign head_preg_o = mem[head];
    assign empty_o     = count == '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                mem[i] <= PREG_W'(NUM_AREGS + i);   // 32..63 in order
            end
            head  <= '0;
            tail  <= '0;    // Tail wrapped onto head when full
            count <= (FL_IDX_W + 1)'(FL_DEPTH);
        end else begin
            if (push_i) begin
                mem[tail] <= push_preg_i;
                tail      <= tail + 1'b1;
            end
            if (pop_i) begin
                head <= head + 1'b1;
            end
            if (push_i && !pop_i) begin
                count <= count + 1'b1;
            end else if (pop_i && !push_i) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: logic/rat.sv
module rat
    import rename_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [AREG_W-1:0] rs1_i,
    input  logic [AREG_W-1:0] rs2_i,
    output logic [PREG_W-1:0] ps1_o,
    output logic [PREG_W-1:0] ps2_o,
    input  logic              we_i,
    input  logic [AREG_W-1:0] rd_i,
    input  logic [PREG_W-1:0] pd_i
);

    logic [PREG_W-1:0] map [NUM_AREGS];

    // Old mapping visible until the edge
    assign ps1_o = map[rs1_i];
    assign ps2_o = map[rs2_i];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_AREGS; i++) begin
                map[i] <= PREG_W'(i);   // Identity at reset
            end
        end else if (we_i) begin
            map[rd_i] <= pd_i;          // Dispatch never writes x0
        end
    end

endmodule

// File: logic/rename_dispatch.sv
module rename_dispatch
    import rename_pkg::*;
(
    input  op_e                  q_op_i,
    input  logic [AREG_W-1:0]    q_rd_i,
    input  logic [AREG_W-1:0]    q_rs1_i,
    input  logic [AREG_W-1:0]    q_rs2_i,
    input  logic                 q_valid_i,
    output logic                 q_ready_o,

    output logic                 uop_valid_o,
    input  logic                 uop_ready_i,
    output logic [PREG_W-1:0]    uop_pd_o,
    output logic [PREG_W-1:0]    uop_ps1_o,
    output logic [PREG_W-1:0]    uop_ps2_o,
    output logic [ROB_IDX_W-1:0] uop_rob_idx_o,
    output logic                 uop_wr_o,

    output logic [AREG_W-1:0]    rat_rs1_o,
    output logic [AREG_W-1:0]    rat_rs2_o,
    input  logic [PREG_W-1:0]    rat_ps1_i,
    input  logic [PREG_W-1:0]    rat_ps2_i,
    output logic                 rat_we_o,
    output logic [AREG_W-1:0]    rat_rd_o,
    output logic [PREG_W-1:0]    rat_pd_o,

    output logic                 fl_pop_o,
    input  logic [PREG_W-1:0]    fl_preg_i,
    input  logic                 fl_empty_i,

    output logic                 rob_alloc_o,
    output logic [AREG_W-1:0]    rob_rd_o,
    output logic                 rob_wr_o,
    input  logic [ROB_IDX_W-1:0] rob_tail_i,
    input  logic                 rob_full_i
);

    logic reads_rs1;
    logic reads_rs2;
    logic uses_rd;
    logic fire;

    assign reads_rs1 = q_op_i != OP_LUI;
    assign reads_rs2 = (q_op_i == OP_REG) || (q_op_i == OP_STORE);
    assign uses_rd   = q_op_i != OP_STORE;
    assign uop_wr_o  = uses_rd && (q_rd_i != '0);   // x0 is never renamed

    assign rat_rs1_o = q_rs1_i;
    assign rat_rs2_o = q_rs2_i;
    assign uop_ps1_o = reads_rs1 ? rat_ps1_i : '0;
    assign uop_ps2_o = reads_rs2 ? rat_ps2_i : '0;
    assign uop_pd_o  = uop_wr_o ? fl_preg_i : '0;
    assign uop_rob_idx_o = rob_tail_i;

    // A uop without rd does not need a free register
    assign uop_valid_o = q_valid_i && !rob_full_i && !(uop_wr_o && fl_empty_i);
    assign fire        = uop_valid_o && uop_ready_i;

    assign q_ready_o   = fire;
    assign fl_pop_o    = fire && uop_wr_o;
    assign rat_we_o    = fire && uop_wr_o;
    assign rat_rd_o    = q_rd_i;
    assign rat_pd_o    = fl_preg_i;
    assign rob_alloc_o = fire;
    assign rob_rd_o    = q_rd_i;
    assign rob_wr_o    = uop_wr_o;

endmodule

// File: logic/rob.sv
module rob
    import rename_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 alloc_i,
    input  logic [AREG_W-1:0]    alloc_rd_i,
    input  logic [PREG_W-1:0]    alloc_pd_i,
    input  logic                 alloc_wr_i,
    output logic [ROB_IDX_W-1:0] tail_o,
    output logic                 full_o,

    input  logic                 cmp_valid_i,
    input  logic [ROB_IDX_W-1:0] cmp_idx_i,

    output logic                 ret_valid_o,
    output logic [AREG_W-1:0]    ret_rd_o,
    output logic [PREG_W-1:0]    ret_pd_o,
    output logic                 ret_wr_o
);

    logic [AREG_W-1:0]    ent_rd [ROB_DEPTH];
    logic [PREG_W-1:0]    ent_pd [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] ent_wr;
    logic [ROB_DEPTH-1:0] ent_busy;
    logic [ROB_DEPTH-1:0] ent_done;
    logic [ROB_IDX_W-1:0] head;
    logic [ROB_IDX_W-1:0] tail;
    logic                 retire;

    assign tail_o = tail;
    assign full_o = ent_busy[tail];     // Tail meets a busy entry only when all are busy

    assign retire      = ent_busy[head] && ent_done[head];
    assign ret_valid_o = retire;
    assign ret_rd_o    = ent_rd[head];
    assign ret_pd_o    = ent_pd[head];
    assign ret_wr_o    = retire && ent_wr[head];

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            ent_rd[tail] <= alloc_rd_i;
            ent_pd[tail] <= alloc_pd_i;
            ent_wr[tail] <= alloc_wr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_busy <= '0;
            ent_done <= '0;
            head     <= '0;
            tail     <= '0;
        end else begin
            if (cmp_valid_i && ent_busy[cmp_idx_i]) begin
                ent_done[cmp_idx_i] <= 1'b1;    // Stale completions dropped
            end
            if (retire) begin
                ent_busy[head] <= 1'b0;
                head           <= head + 1'b1;
            end
            if (alloc_i) begin
                ent_busy[tail] <= 1'b1;
                ent_done[tail] <= 1'b0;
                tail           <= tail + 1'b1;
            end
        end
    end

endmodule

// File: logic/rrat.sv
module rrat
    import rename_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              ret_valid_i,
    input  logic              ret_wr_i,
    input  logic [AREG_W-1:0] ret_rd_i,
    input  logic [PREG_W-1:0] ret_pd_i,
    output logic [PREG_W-1:0] old_pd_o,
    output logic              free_o
);

    logic [PREG_W-1:0] map [NUM_AREGS];

    assign old_pd_o = map[ret_rd_i];    // Committed mapping being replaced
    assign free_o   = ret_valid_i && ret_wr_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_AREGS; i++) begin
                map[i] <= PREG_W'(i);
            end
        end else if (free_o) begin
            map[ret_rd_i] <= ret_pd_i;
        end
    end

endmodule

// File: logic/rename_core.sv
module rename_core
    import rename_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  op_e                  in_op_i,
    input  logic [AREG_W-1:0]    in_rd_i,
    input  logic [AREG_W-1:0]    in_rs1_i,
    input  logic [AREG_W-1:0]    in_rs2_i,
    input  logic                 in_valid_i,
    output logic                 in_ready_o,

    output logic                 uop_valid_o,
    input  logic                 uop_ready_i,
    output logic [PREG_W-1:0]    uop_pd_o,
    output logic [PREG_W-1:0]    uop_ps1_o,
    output logic [PREG_W-1:0]    uop_ps2_o,
    output logic [ROB_IDX_W-1:0] uop_rob_idx_o,
    output logic                 uop_wr_o,

    input  logic                 cmp_valid_i,
    input  logic [ROB_IDX_W-1:0] cmp_idx_i,

    output logic                 ret_valid_o,
    output logic [AREG_W-1:0]    ret_rd_o,
    output logic [PREG_W-1:0]    ret_pd_o,
    output logic                 ret_wr_o,
    output logic [PREG_W-1:0]    ret_old_pd_o
);

    logic [INST_W-1:0]    in_word;
    logic [INST_W-1:0]    q_word;
    logic                 q_valid;
    logic                 q_ready;
    op_e                  q_op;
    logic [AREG_W-1:0]    q_rd;
    logic [AREG_W-1:0]    q_rs1;
    logic [AREG_W-1:0]    q_rs2;

    logic [AREG_W-1:0]    rat_rs1;
    logic [AREG_W-1:0]    rat_rs2;
    logic [PREG_W-1:0]    rat_ps1;
    logic [PREG_W-1:0]    rat_ps2;
    logic                 rat_we;
    logic [AREG_W-1:0]    rat_rd;
    logic [PREG_W-1:0]    rat_pd;

    logic                 fl_pop;
    logic [PREG_W-1:0]    fl_preg;
    logic                 fl_empty;
    logic                 fl_push;

    logic                 rob_alloc;
    logic [AREG_W-1:0]    rob_rd;
    logic                 rob_wr;
    logic [ROB_IDX_W-1:0] rob_tail;
    logic                 rob_full;

    assign in_word = {in_op_i, in_rd_i, in_rs1_i, in_rs2_i};
    assign q_op    = op_e'(q_word[INST_W-1 -: OP_W]);
    assign q_rd    = q_word[3*AREG_W-1 -: AREG_W];
    assign q_rs1   = q_word[2*AREG_W-1 -: AREG_W];
    assign q_rs2   = q_word[AREG_W-1:0];

    inst_queue #(.WIDTH(INST_W), .DEPTH(IQ_DEPTH)) inst_queue_i (
        .clk(clk), .rst(rst),
        .wdata_i(in_word), .wvalid_i(in_valid_i), .wready_o(in_ready_o),
        .rdata_o(q_word), .rvalid_o(q_valid), .rready_i(q_ready)
    );

    rename_dispatch rename_dispatch_i (
        .q_op_i(q_op), .q_rd_i(q_rd), .q_rs1_i(q_rs1), .q_rs2_i(q_rs2),
        .q_valid_i(q_valid), .q_ready_o(q_ready),
        .uop_valid_o(uop_valid_o), .uop_ready_i(uop_ready_i),
        .uop_pd_o(uop_pd_o), .uop_ps1_o(uop_ps1_o), .uop_ps2_o(uop_ps2_o),
        .uop_rob_idx_o(uop_rob_idx_o), .uop_wr_o(uop_wr_o),
        .rat_rs1_o(rat_rs1), .rat_rs2_o(rat_rs2),
        .rat_ps1_i(rat_ps1), .rat_ps2_i(rat_ps2),
        .rat_we_o(rat_we), .rat_rd_o(rat_rd), .rat_pd_o(rat_pd),
        .fl_pop_o(fl_pop), .fl_preg_i(fl_preg), .fl_empty_i(fl_empty),
        .rob_alloc_o(rob_alloc), .rob_rd_o(rob_rd), .rob_wr_o(rob_wr),
        .rob_tail_i(rob_tail), .rob_full_i(rob_full)
    );

    rat rat_i (
        .clk(clk), .rst(rst),
        .rs1_i(rat_rs1), .rs2_i(rat_rs2), .ps1_o(rat_ps1), .ps2_o(rat_ps2),
        .we_i(rat_we), .rd_i(rat_rd), .pd_i(rat_pd)
    );

    // Retired old mappings flow back into the free list
    free_list free_list_i (
        .clk(clk), .rst(rst),
        .push_i(fl_push), .push_preg_i(ret_old_pd_o),
        .pop_i(fl_pop), .head_preg_o(fl_preg), .empty_o(fl_empty)
    );

    rob rob_i (
        .clk(clk), .rst(rst),
        .alloc_i(rob_alloc), .alloc_rd_i(rob_rd), .alloc_pd_i(uop_pd_o),
        .alloc_wr_i(rob_wr), .tail_o(rob_tail), .full_o(rob_full),
        .cmp_valid_i(cmp_valid_i), .cmp_idx_i(cmp_idx_i),
        .ret_valid_o(ret_valid_o), .ret_rd_o(ret_rd_o),
        .ret_pd_o(ret_pd_o), .ret_wr_o(ret_wr_o)
    );

    rrat rrat_i (
        .clk(clk), .rst(rst),
        .ret_valid_i(ret_valid_o), .ret_wr_i(ret_wr_o),
        .ret_rd_i(ret_rd_o), .ret_pd_i(ret_pd_o),
        .old_pd_o(ret_old_pd_o), .free_o(fl_push)
    );

endmodule

// File: verification/rename_assert.sv
module rename_assert
    import rename_pkg::*;
(
    input logic                 clk,
    input logic                 rst,
    input logic                 uop_valid_i,
    input logic                 uop_ready_i,
    input logic [PREG_W-1:0]    uop_pd_i,
    input logic [PREG_W-1:0]    uop_ps1_i,
    input logic [PREG_W-1:0]    uop_ps2_i,
    input logic [ROB_IDX_W-1:0] uop_rob_idx_i,
    input logic                 uop_wr_i,
    input logic                 ret_valid_i,
    input logic                 ret_wr_i,
    input logic [PREG_W-1:0]    ret_old_pd_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // Stalled uop keeps its fields
    assert property (@(posedge clk) disable iff (rst)
        uop_valid_i && !uop_ready_i |=> uop_valid_i
            && $stable({uop_pd_i, uop_ps1_i, uop_ps2_i, uop_rob_idx_i, uop_wr_i}))
    else begin
        fail_count++;
        $error("uop changed or dropped while stalled");
    end

    assert property (@(posedge clk) rst && $past(rst) |-> !uop_valid_i && !ret_valid_i)
    else begin
        fail_count++;
        $error("output valid high during reset");
    end

    assert property (@(posedge clk) disable iff (rst) ret_wr_i |-> ret_old_pd_i != '0)
    else begin
        fail_count++;
        $error("physical register 0 freed at retirement");
    end

endmodule

bind rename_core rename_assert rename_assert_i (
    .clk(clk), .rst(rst),
    .uop_valid_i(uop_valid_o), .uop_ready_i(uop_ready_i),
    .uop_pd_i(uop_pd_o), .uop_ps1_i(uop_ps1_o), .uop_ps2_i(uop_ps2_o),
    .uop_rob_idx_i(uop_rob_idx_o), .uop_wr_i(uop_wr_o),
    .ret_valid_i(ret_valid_o), .ret_wr_i(ret_wr_o), .ret_old_pd_i(ret_old_pd_o)
);

// File: verification/rename_tb.sv
module rename_tb
    import rename_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_INST = 300;
    localparam int TIMEOUT  = NUM_INST * 40 * 4;    // 40 cycles of 4 ns per instruction

    logic                 clk;
    logic                 rst;
    op_e                  in_op_i;
    logic [AREG_W-1:0]    in_rd_i, in_rs1_i, in_rs2_i, ret_rd_o;
    logic                 in_valid_i, in_ready_o, uop_valid_o, uop_ready_i, uop_wr_o;
    logic [PREG_W-1:0]    uop_pd_o, uop_ps1_o, uop_ps2_o, ret_pd_o, ret_old_pd_o;
    logic [ROB_IDX_W-1:0] uop_rob_idx_o, cmp_idx_i;
    logic                 cmp_valid_i, ret_valid_o, ret_wr_o;

    logic [PREG_W-1:0]    m_rat [NUM_AREGS];
    logic [PREG_W-1:0]    m_rrat [NUM_AREGS];
    logic [PREG_W-1:0]    m_free [$];
    logic [ROB_IDX_W-1:0] m_tail;
    logic [ROB_DEPTH-1:0] m_done;
    logic [INST_W-1:0]    pend_q [$];       // Accepted but not yet dispatched
    logic [ROB_IDX_W-1:0] rob_idx_q [$];    // In flight in program order
    logic [AREG_W-1:0]    rob_rd_q [$];
    logic [PREG_W:0]      rob_wpd_q [$];    // {wr, pd}
    logic [ROB_IDX_W-1:0] cmp_list [$];
    int                   sent;
    int                   retired;
    int                   cycle;
    logic                 saw_in_stall;
    logic                 saw_rob_full;

    rename_core dut_i (.*);

    always #2 clk = ~clk;

    task automatic check_value(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    function automatic logic writes_rd(input logic [INST_W-1:0] inst);
        return (inst[INST_W-1 -: OP_W] != OP_STORE) && (inst[3*AREG_W-1 -: AREG_W] != '0);
    endfunction

    function automatic void rename_ref(input logic [INST_W-1:0] inst,
                                       output logic [PREG_W-1:0] pd,
                                       output logic [PREG_W-1:0] ps1,
                                       output logic [PREG_W-1:0] ps2);
        op_e               op;
        logic [AREG_W-1:0] rd;
        op  = op_e'(inst[INST_W-1 -: OP_W]);
        rd  = inst[3*AREG_W-1 -: AREG_W];
        ps1 = (op == OP_LUI) ? '0 : m_rat[inst[2*AREG_W-1 -: AREG_W]];
        ps2 = (op == OP_REG || op == OP_STORE) ? m_rat[inst[AREG_W-1:0]] : '0;
        pd  = '0;
        if (writes_rd(inst)) begin
            pd        = m_free.pop_front();
            m_rat[rd] = pd;
        end
        rob_idx_q.push_back(m_tail);
        rob_rd_q.push_back(rd);
        rob_wpd_q.push_back({writes_rd(inst), pd});
        m_tail = m_tail + 1'b1;
    endfunction

    function automatic void retire_ref(output logic [AREG_W-1:0] rd,
                                       output logic [PREG_W:0] wpd,
                                       output logic [PREG_W-1:0] old_pd);
        logic [ROB_IDX_W-1:0] idx;
        idx         = rob_idx_q.pop_front();
        m_done[idx] = 1'b0;
        rd          = rob_rd_q.pop_front();
        wpd         = rob_wpd_q.pop_front();
        old_pd      = m_rrat[rd];
        if (wpd[PREG_W]) begin
            m_rrat[rd] = wpd[PREG_W-1:0];
            m_free.push_back(old_pd);   // Reusable after older ones
        end
    endfunction

    always @(posedge clk) begin : compare
        logic [PREG_W-1:0] pd, ps1, ps2, old_pd;
        logic [AREG_W-1:0] rd;
        logic [PREG_W:0]   wpd;
        logic              exp_valid;
        logic              exp_ret;
        if (!rst) begin
            exp_valid = pend_q.size() > 0 && rob_idx_q.size() < ROB_DEPTH;
            if (exp_valid && writes_rd(pend_q[0]) && m_free.size() == 0) begin
                exp_valid = 1'b0;
            end
            exp_ret = rob_idx_q.size() > 0 && m_done[rob_idx_q[0]];
            saw_rob_full = saw_rob_full || rob_idx_q.size() == ROB_DEPTH;
            saw_in_stall = saw_in_stall || !in_ready_o;
            check_value("uop_valid_o", int'(uop_valid_o), int'(exp_valid));
            check_value("in_ready_o", int'(in_ready_o), int'(pend_q.size() < IQ_DEPTH));
            check_value("ret_valid_o", int'(ret_valid_o), int'(exp_ret));
            if (uop_valid_o && uop_ready_i) begin
                check_value("uop_wr_o", int'(uop_wr_o), int'(writes_rd(pend_q[0])));
                check_value("uop_rob_idx_o", int'(uop_rob_idx_o), int'(m_tail));
                rename_ref(pend_q.pop_front(), pd, ps1, ps2);
                check_value("uop_pd_o", int'(uop_pd_o), int'(pd));
                check_value("uop_ps1_o", int'(uop_ps1_o), int'(ps1));
                check_value("uop_ps2_o", int'(uop_ps2_o), int'(ps2));
            end
            if (ret_valid_o) begin
                retire_ref(rd, wpd, old_pd);
                check_value("ret_rd_o", int'(ret_rd_o), int'(rd));
                check_value("ret_pd_o", int'(ret_pd_o), int'(wpd[PREG_W-1:0]));
                check_value("ret_wr_o", int'(ret_wr_o), int'(wpd[PREG_W]));
                check_value("ret_old_pd_o", int'(ret_old_pd_o), int'(old_pd));
                retired = retired + 1;
            end
            if (cmp_valid_i) begin
                m_done[cmp_idx_i] = 1'b1;
            end
            if (in_valid_i && in_ready_o) begin
                pend_q.push_back({in_op_i, in_rd_i, in_rs1_i, in_rs2_i});
            end
        end
    end

    always @(posedge clk) begin : drive_inputs
        if (!rst) begin
            cycle = cycle + 1;
            // Light and heavy back-pressure alternate every 64 cycles
            uop_ready_i <= $urandom_range(99) < (((cycle / 64) % 2 == 1) ? 20 : 90);
            if (in_valid_i && in_ready_o) begin
                sent = sent + 1;
            end
            if (!in_valid_i || in_ready_o) begin
                in_valid_i <= sent < NUM_INST && $urandom_range(4) != 0;
                in_op_i    <= op_e'(OP_W'($urandom_range(3)));
                in_rd_i    <= AREG_W'($urandom_range(NUM_AREGS - 1));
                in_rs1_i   <= AREG_W'($urandom_range(NUM_AREGS - 1));
                in_rs2_i   <= AREG_W'($urandom_range(NUM_AREGS - 1));
            end
        end
    end

    always @(posedge clk) begin : complete_uops
        int pick;
        cmp_valid_i <= 1'b0;
        if (!rst && cmp_list.size() > 0 && $urandom_range(1) == 1) begin
            pick = $urandom_range(cmp_list.size() - 1);
            cmp_valid_i <= 1'b1;
            cmp_idx_i   <= cmp_list[pick];
            cmp_list.delete(pick);
        end
        if (!rst && uop_valid_o && uop_ready_i) begin
            cmp_list.push_back(uop_rob_idx_o);
        end
    end

    initial begin : watchdog
        #(TIMEOUT);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT);
        $display("Checks failed");
        $fatal(1);
    end

    initial begin
        void'($urandom(4));
        clk          = 1'b0;
        rst          = 1'b1;
        in_valid_i   = 1'b0;
        in_op_i      = OP_REG;
        in_rd_i      = '0;
        in_rs1_i     = '0;
        in_rs2_i     = '0;
        uop_ready_i  = 1'b0;
        cmp_valid_i  = 1'b0;
        cmp_idx_i    = '0;
        sent         = 0;
        retired      = 0;
        cycle        = 0;
        m_tail       = '0;
        m_done       = '0;
        saw_in_stall = 1'b0;
        saw_rob_full = 1'b0;
        for (int i = 0; i < NUM_AREGS; i++) begin
            m_rat[i]  = PREG_W'(i);
            m_rrat[i] = PREG_W'(i);
            m_free.push_back(PREG_W'(NUM_AREGS + i));   // 32 spare registers
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        wait (retired == NUM_INST);
        repeat (4) @(posedge clk);
        if (!saw_in_stall || !saw_rob_full || dut_i.rename_assert_i.fail_count != 0) begin
            $display("End of run: input stall seen %0b, ROB full seen %0b, assertion failures %0d",
                     saw_in_stall, saw_rob_full, dut_i.rename_assert_i.fail_count);
            $display("Checks failed");
            $fatal(1);
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

// File: vlog.f
logic/rename_pkg.sv
logic/inst_queue.sv
logic/free_list.sv
logic/rat.sv
logic/rename_dispatch.sv
logic/rob.sv
logic/rrat.sv
logic/rename_core.sv
verification/rename_assert.sv
verification/rename_tb.sv

// File: Makefile
SIM       = verilator
FLAGS     = --binary --timing --assert
TOP       = rename_tb
FILE_LIST = vlog.f
PASS_MSG  = All checks passed
BIN       = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)

run: build
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(SIM) --lint-only -Wall --timing --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf obj_dir
